//--- Makefile
sim:
	verilator --binary --timing --assert -f ltc2195_ctrl.f --top-module ltc2195_tb -Mdir obj_dir
	./obj_dir/Vltc2195_tb | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- include/ltc2195_settings.svh
/* Widths, SPI command codes, wait times and training pattern
   of the LTC2195 controller */
`ifndef LTC2195_SETTINGS_SVH
`define LTC2195_SETTINGS_SVH

//////////////////////////////
// SPI link
`define LTC_SPI_WIDTH      16                  // Bits per SPI frame
`define LTC_SPI_HALF_DIV   5                   // clk_in cycles per SCK half period
`define LTC_POR_WAIT       256                 // Cycles after reset before first write
`define LTC_CMD_WRITE      8'h31               // Upper address byte of a host write

// Power-up register writes, {rw, addr, data}
`define LTC_INIT_RESET     {1'b0, 7'h00, 8'h80} // Software reset
`define LTC_INIT_FORMAT    {1'b0, 7'h01, 8'h20} // Two's complement output
`define LTC_INIT_LANES     {1'b0, 7'h02, 8'h00} // 2-lane output mode

//////////////////////////////
// Serial data path
`define LTC_SER_BITS       8                   // Bits per lane word
`define LTC_N_LANES        5                   // Ch0 a/b, ch1 a/b, frame
`define LTC_FRAME_PATTERN  8'b00001111         // Frame lane training word
`define LTC_SLIP_SETTLE    2                   // Words skipped after a slip

`endif

//--- ltc2195_ctrl.f
+incdir+include
src/ltc2195_pkg.sv
src/spi_master.sv
src/adc_config_seq.sv
src/lane_deserializer.sv
src/frame_aligner.sv
src/sample_assembler.sv
src/ltc2195_ctrl.sv
test/ltc2195_chk.sv
test/ltc2195_tb.sv

//--- src/adc_config_seq.sv
/* Configuration sequencer, power-up register writes and host write commands */
`default_nettype none

`include "ltc2195_settings.svh"

module adc_config_seq (
	input  wire                          clk_in,
	input  wire                          rst_in,
	input  wire                          cmd_trig,     // Host command strobe
	input  wire  [15:0]                  cmd_addr,     // {command code, register address}
	input  wire  ltc2195_pkg::reg_data_t cmd_data,
	input  wire                          spi_ready,
	output logic                         spi_start,
	output ltc2195_pkg::spi_word_t       spi_word
);

	localparam int PW           = $clog2(`LTC_POR_WAIT + 1);
	localparam logic [1:0] N_INIT = 2'd3;               // Words in the power-up sequence

	ltc2195_pkg::cfg_state_t state;
	logic [PW-1:0] por_cnt;                             // Power-up wait countdown
	logic [1:0]    init_idx;                            // Init words loaded so far
	logic          host_write;

	// Write command decode, only taken while idle
	assign host_write = (state == ltc2195_pkg::CFG_IDLE) && cmd_trig &&
		(cmd_addr[15:8] == `LTC_CMD_WRITE);

	//////////////////////////////
	// Control FSM
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state     <= ltc2195_pkg::CFG_POR;
			por_cnt   <= PW'(`LTC_POR_WAIT);
			init_idx  <= '0;
			spi_start <= 1'b0;
		end else begin
			case (state)
				ltc2195_pkg::CFG_POR: begin
					if (por_cnt == PW'(1))
						state <= ltc2195_pkg::CFG_LOAD;
					por_cnt <= por_cnt - 1'b1;
				end
				ltc2195_pkg::CFG_LOAD: begin
					init_idx <= init_idx + 1'b1;
					state    <= ltc2195_pkg::CFG_WAIT;
				end
				ltc2195_pkg::CFG_WAIT: begin
					if (spi_ready) begin                // Previous frame finished
						spi_start <= 1'b1;
						state     <= ltc2195_pkg::CFG_START;
					end
				end
				ltc2195_pkg::CFG_START: begin
					spi_start <= 1'b0;                  // Master drops ready next cycle
					if (init_idx == N_INIT)
						state <= ltc2195_pkg::CFG_IDLE;
					else
						state <= ltc2195_pkg::CFG_LOAD;
				end
				ltc2195_pkg::CFG_IDLE: begin
					if (host_write)
						state <= ltc2195_pkg::CFG_WAIT;
				end
				default: state <= ltc2195_pkg::CFG_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// Frame register
	always_ff @(posedge clk_in) begin
		if (state == ltc2195_pkg::CFG_LOAD) begin
			case (init_idx)
				2'd0:    spi_word <= `LTC_INIT_RESET;
				2'd1:    spi_word <= `LTC_INIT_FORMAT;
				default: spi_word <= `LTC_INIT_LANES;
			endcase
		end else if (host_write) begin
			spi_word.rw   <= 1'b0;                      // Write
			spi_word.addr <= cmd_addr[6:0];
			spi_word.data <= cmd_data;
		end
	end

endmodule

`default_nettype wire

//--- src/frame_aligner.sv
/* Frame aligner, slips the word boundary until the frame lane
   shows the training pattern, then locks */
`default_nettype none

`include "ltc2195_settings.svh"

module frame_aligner (
	input  wire                         clk_in,
	input  wire                         rst_in,
	input  wire  ltc2195_pkg::lane_word_t frame_word,   // Frame lane word
	input  wire                         word_valid,
	output logic                        bitslip,        // One-cycle slip request
	output logic                        locked          // Held until reset
);

	localparam int SETTLE = `LTC_SLIP_SETTLE;
	localparam int SW     = $clog2(SETTLE + 1);

	ltc2195_pkg::align_state_t state;
	logic [SW-1:0] settle_cnt;                      // Words still to skip after a slip

	assign locked = (state == ltc2195_pkg::ALIGN_LOCKED);

	//////////////////////////////
	// Alignment FSM
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state      <= ltc2195_pkg::ALIGN_CHECK;
			settle_cnt <= '0;
			bitslip    <= 1'b0;
		end else begin
			case (state)
				ltc2195_pkg::ALIGN_CHECK: begin
					if (word_valid) begin
						if (settle_cnt != '0) begin
							// Word may still straddle the old boundary
							settle_cnt <= settle_cnt - 1'b1;
						end else if (frame_word == `LTC_FRAME_PATTERN) begin
							state <= ltc2195_pkg::ALIGN_LOCKED;
						end else begin
							bitslip    <= 1'b1;         // Mismatch, shift by one bit
							settle_cnt <= SW'(SETTLE);
							state      <= ltc2195_pkg::ALIGN_SLIP;
						end
					end
				end
				ltc2195_pkg::ALIGN_SLIP: begin
					bitslip <= 1'b0;                    // Single-cycle pulse
					state   <= ltc2195_pkg::ALIGN_CHECK;
				end
				ltc2195_pkg::ALIGN_LOCKED: begin
					bitslip <= 1'b0;
				end
				default: state <= ltc2195_pkg::ALIGN_CHECK;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/lane_deserializer.sv
/* 1:8 deserializer for the five ADC lanes, with shared bit slip */
`default_nettype none

`include "ltc2195_settings.svh"

module lane_deserializer (
	input  wire                         clk_in,
	input  wire                         rst_in,
	input  wire  [`LTC_N_LANES-1:0]     ser_in,     // One bit per lane per cycle
	input  wire                         bitslip,    // Move word boundary one bit later
	output ltc2195_pkg::lane_words_t    lane_words,
	output logic                        word_valid
);

	localparam int N  = `LTC_N_LANES;
	localparam int B  = `LTC_SER_BITS;
	localparam int CW = $clog2(B);

	ltc2195_pkg::lane_words_t shreg;                // Per-lane shift registers
	logic [CW-1:0] bit_cnt;                         // Shared position within a word
	logic          word_done;

	// Last bit of a word, unless the counter is held for a slip
	assign word_done = (bit_cnt == CW'(B - 1)) && !bitslip;

	//////////////////////////////
	// Shift and capture
	// First received bit ends up as the MSB
	always_ff @(posedge clk_in) begin
		for (int i = 0; i < N; i++) begin
			shreg[i] <= {shreg[i][B-2:0], ser_in[i]};
			if (word_done)
				lane_words[i] <= {shreg[i][B-2:0], ser_in[i]};
		end
	end

	// Bit counter, holds for one cycle per slip
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			bit_cnt    <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= word_done;
			if (word_done)
				bit_cnt <= '0;
			else if (!bitslip)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/ltc2195_ctrl.sv
/* LTC2195 controller top, configuration sequencer with SPI master
   and the frame-aligned sample path */
`default_nettype none

`include "ltc2195_settings.svh"

module ltc2195_ctrl (
	input  wire                          clk_in,
	input  wire                          rst_in,
	input  wire                          cmd_trig,
	input  wire  [15:0]                  cmd_addr,
	input  wire  ltc2195_pkg::reg_data_t cmd_data,
	output logic                         spi_scs,
	output logic                         spi_sck,
	output logic                         spi_sdo,
	input  wire  [`LTC_N_LANES-1:0]      ser_in,
	output ltc2195_pkg::sample_t         adc0_sample,
	output ltc2195_pkg::sample_t         adc1_sample,
	output logic                         sample_valid,
	output logic                         locked
);

	logic                     spi_start;        // Sequencer to SPI master
	logic                     spi_ready;
	ltc2195_pkg::spi_word_t   spi_word;
	ltc2195_pkg::lane_words_t lane_words;       // Deserialized words, frame lane on top
	logic                     word_valid;
	logic                     bitslip;

	//////////////////////////////
	// Configuration path
	adc_config_seq u_seq (
		.clk_in(clk_in), .rst_in(rst_in),
		.cmd_trig(cmd_trig), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.spi_ready(spi_ready), .spi_start(spi_start), .spi_word(spi_word)
	);

	spi_master u_spi (
		.clk_in(clk_in), .rst_in(rst_in),
		.start(spi_start), .word(spi_word), .ready(spi_ready),
		.spi_scs(spi_scs), .spi_sck(spi_sck), .spi_sdo(spi_sdo)
	);

	//////////////////////////////
	// Sample path
	lane_deserializer u_deser (
		.clk_in(clk_in), .rst_in(rst_in), .ser_in(ser_in), .bitslip(bitslip),
		.lane_words(lane_words), .word_valid(word_valid)
	);

	frame_aligner u_align (
		.clk_in(clk_in), .rst_in(rst_in),
		.frame_word(lane_words[`LTC_N_LANES-1]), .word_valid(word_valid),
		.bitslip(bitslip), .locked(locked)
	);

	sample_assembler u_asm (
		.clk_in(clk_in), .rst_in(rst_in),
		.lane_words(lane_words), .word_valid(word_valid), .locked(locked),
		.adc0_sample(adc0_sample), .adc1_sample(adc1_sample),
		.sample_valid(sample_valid)
	);

endmodule

`default_nettype wire

//--- src/ltc2195_pkg.sv
/* Shared types of the LTC2195 controller: SPI frame, lane words,
   samples and FSM state encodings */
`default_nettype none

`include "ltc2195_settings.svh"

package ltc2195_pkg;

	//////////////////////////////
	// SPI register access
	typedef logic [6:0] reg_addr_t;             // ADC register address
	typedef logic [7:0] reg_data_t;             // ADC register value

	// One SPI frame, sent MSB first
	typedef struct packed {
		logic      rw;                          // 0 = write
		reg_addr_t addr;
		reg_data_t data;
	} spi_word_t;

	//////////////////////////////
	// Sample path
	typedef logic [`LTC_SER_BITS-1:0] lane_word_t;          // One deserialized lane word
	typedef lane_word_t [`LTC_N_LANES-1:0] lane_words_t;    // 0/1 ch0, 2/3 ch1, 4 frame
	typedef logic signed [2*`LTC_SER_BITS-1:0] sample_t;    // Assembled ADC sample

	// Configuration sequencer states
	typedef enum logic [2:0] {
		CFG_POR,                                // Power-up wait
		CFG_LOAD,                               // Load next init word
		CFG_WAIT,                               // Wait for SPI master idle
		CFG_START,                              // Start pulse high
		CFG_IDLE                                // Accept host writes
	} cfg_state_t;

	// Frame aligner states
	typedef enum logic [1:0] {
		ALIGN_CHECK,
		ALIGN_SLIP,
		ALIGN_LOCKED
	} align_state_t;

endpackage

`default_nettype wire

//--- src/sample_assembler.sv
/* Sample assembler, interleaves each channel's two lane words into a signed sample */
`default_nettype none

module sample_assembler (
	input  wire                          clk_in,
	input  wire                          rst_in,
	input  wire  ltc2195_pkg::lane_words_t lane_words,
	input  wire                          word_valid,
	input  wire                          locked,
	output ltc2195_pkg::sample_t         adc0_sample,
	output ltc2195_pkg::sample_t         adc1_sample,
	output logic                         sample_valid
);

	localparam int B = $bits(ltc2195_pkg::lane_word_t);
	localparam int CH0_A = 0;                       // Lane indices
	localparam int CH0_B = 1;
	localparam int CH1_A = 2;
	localparam int CH1_B = 3;

	// Lane a carries the odd sample bits, lane b the even ones
	function automatic ltc2195_pkg::sample_t interleave(
		input ltc2195_pkg::lane_word_t a,
		input ltc2195_pkg::lane_word_t b
	);
		ltc2195_pkg::sample_t s;
		int k;
		for (k = 0; k < B; k++) begin
			s[2*B-1-2*k] = a[B-1-k];
			s[2*B-2-2*k] = b[B-1-k];
		end
		return s;
	endfunction

	//////////////////////////////
	// Sample registers
	always_ff @(posedge clk_in) begin
		if (word_valid && locked) begin
			adc0_sample <= interleave(lane_words[CH0_A], lane_words[CH0_B]);
			adc1_sample <= interleave(lane_words[CH1_A], lane_words[CH1_B]);
		end
	end

	// Strobe one cycle after each aligned word
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in)
			sample_valid <= 1'b0;
		else
			sample_valid <= word_valid && locked;
	end

endmodule

`default_nettype wire

//--- src/spi_master.sv
/* SPI master, shifts one 16-bit frame out MSB first on SCS/SCK/SDO */
`default_nettype none

`include "ltc2195_settings.svh"

module spi_master (
	input  wire                   clk_in,
	input  wire                   rst_in,
	input  wire                   start,        // One-cycle start strobe
	input  wire ltc2195_pkg::spi_word_t word,   // Frame to send
	output logic                  ready,        // High while idle
	output logic                  spi_scs,
	output logic                  spi_sck,
	output logic                  spi_sdo
);

	localparam int W         = `LTC_SPI_WIDTH;
	localparam int HALF_DIV  = `LTC_SPI_HALF_DIV;
	localparam int LAST_HALF = 2*W + 1;                 // Two lead-in halves, two per bit
	localparam int DW        = $clog2(HALF_DIV + 1);
	localparam int HW        = $clog2(LAST_HALF + 1);

	logic [DW-1:0] div_cnt;                             // Cycles within a half period
	logic [HW-1:0] half_cnt;                            // Half periods since SCS fell
	logic [W-1:0]  shreg;                               // Outgoing bits, MSB on SDO

	// Bit on the wire is always the shift register MSB
	assign spi_sdo = shreg[W-1];

	//////////////////////////////
	// Frame sequencing
	// Halves 0,1 lead-in with SCK low, then SCK high on even and low on odd halves
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			ready    <= 1'b1;
			spi_scs  <= 1'b1;
			spi_sck  <= 1'b0;
			div_cnt  <= '0;
			half_cnt <= '0;
			shreg    <= '0;
		end else if (ready) begin
			if (start) begin
				ready    <= 1'b0;
				spi_scs  <= 1'b0;                       // Select ADC
				shreg    <= word;                       // MSB valid from SCS fall
				div_cnt  <= '0;
				half_cnt <= '0;
			end
		end else if (div_cnt == DW'(HALF_DIV - 1)) begin
			div_cnt <= '0;
			if (half_cnt == HW'(LAST_HALF)) begin
				// Half period after the last fall
				spi_scs <= 1'b1;
				ready   <= 1'b1;
			end else begin
				half_cnt <= half_cnt + 1'b1;
				if (half_cnt[0]) begin
					spi_sck <= 1'b1;                    // Rising edge, ADC samples SDO
				end else if (half_cnt != '0) begin
					spi_sck <= 1'b0;                    // Falling edge
					shreg   <= {shreg[W-2:0], 1'b0};    // Next bit out
				end
			end
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- test/ltc2195_chk.sv
/* Bound assertions on SPI chip select and clock, sample strobe and lock */
`default_nettype none

module ltc2195_chk (
	input wire clk_in,
	input wire rst_in,
	input wire spi_scs,
	input wire spi_sck,
	input wire sample_valid,
	input wire locked
);

	//////////////////////////////
	// SPI bus
	// SCK parks low whenever the ADC is deselected
	a_sck_idle: assert property (@(posedge clk_in) disable iff (rst_in)
		spi_scs |-> !spi_sck)
		else $error("SCK high while SCS is high");

	//////////////////////////////
	// Sample path
	a_valid_locked: assert property (@(posedge clk_in) disable iff (rst_in)
		sample_valid |-> locked)                    // No samples from an unaligned stream
		else $error("sample_valid while not locked");

	// Lock holds until the next reset
	a_lock_hold: assert property (@(posedge clk_in) disable iff (rst_in)
		locked |=> locked)
		else $error("locked fell after it rose");

endmodule

`default_nettype wire

//--- test/ltc2195_tb.sv
/* Testbench of the LTC2195 controller with clock and stimulus, SPI monitor,
   reference functions, compares and watchdog */
`default_nettype none

`include "ltc2195_settings.svh"

module ltc2195_tb;

	localparam int CLK_PERIOD  = 40;
	localparam int N_WORDS     = 300;               // Serial words sent at least
	localparam int LOCK_WORDS  = 40;                // Words allowed before lock
	localparam int MIN_SAMPLES = 250;
	localparam int FRAME_CYC   = (2*`LTC_SPI_WIDTH + 2) * `LTC_SPI_HALF_DIV;
	localparam int WATCHDOG_CYC = `LTC_POR_WAIT + 8*FRAME_CYC + 400*`LTC_SER_BITS;
	localparam logic [7:0] FRAME_PAT = `LTC_FRAME_PATTERN;

	logic                    clk_in;
	logic                    rst_in;
	logic                    cmd_trig;
	logic [15:0]             cmd_addr;
	ltc2195_pkg::reg_data_t  cmd_data;
	logic [`LTC_N_LANES-1:0] ser_in;
	logic                    spi_scs;
	logic                    spi_sck;
	logic                    spi_sdo;
	ltc2195_pkg::sample_t    adc0_sample;
	ltc2195_pkg::sample_t    adc1_sample;
	logic                    sample_valid;
	logic                    locked;

	logic [31:0] rng = 32'h1ae114d3;                  // xorshift state
	ltc2195_pkg::spi_word_t exp_spi_q[$];            // Frames still to appear on SPI
	logic [31:0] sent_q[$];                           // {adc0, adc1} per serial word
	logic [15:0] spi_shift;
	int          words_sent = 0;
	int          frames_done = 0;
	int          spi_bits = 0;
	int          n_samples = 0;
	int          next_idx = 0;                        // Next sent_q entry to compare
	logic        sck_d = 1'b0;
	logic        scs_d = 1'b1;
	logic        synced = 1'b0;
	logic        cmds_done = 1'b0;

	ltc2195_ctrl uut (
		.clk_in(clk_in), .rst_in(rst_in),
		.cmd_trig(cmd_trig), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.spi_scs(spi_scs), .spi_sck(spi_sck), .spi_sdo(spi_sdo),
		.ser_in(ser_in),
		.adc0_sample(adc0_sample), .adc1_sample(adc1_sample),
		.sample_valid(sample_valid), .locked(locked)
	);

	bind ltc2195_ctrl ltc2195_chk u_chk (
		.clk_in(clk_in), .rst_in(rst_in), .spi_scs(spi_scs), .spi_sck(spi_sck),
		.sample_valid(sample_valid), .locked(locked)
	);

	//////////////////////////////
	// Helpers and reference model
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at first error");
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	// Write frame is rw low followed by the low 7 address bits and the data
	function automatic ltc2195_pkg::spi_word_t expected_write(input logic [15:0] addr,
		input ltc2195_pkg::reg_data_t data);
		ltc2195_pkg::spi_word_t w;
		w.rw   = 1'b0;
		w.addr = addr[6:0];
		w.data = data;
		return w;
	endfunction

	// Returns {lane a, lane b} where lane a takes the odd sample bits
	function automatic logic [15:0] serialize_sample(input ltc2195_pkg::sample_t s);
		ltc2195_pkg::lane_word_t a;
		ltc2195_pkg::lane_word_t b;
		int k;
		for (k = 0; k < 8; k++) begin
			a[7-k] = s[15-2*k];
			b[7-k] = s[14-2*k];
		end
		return {a, b};
	endfunction

	task automatic check_spi(input ltc2195_pkg::spi_word_t got,
		input ltc2195_pkg::spi_word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH at %0t: SPI frame got %h expected %h",
				$time, got, exp));
	endtask

	task automatic check_sample(input ltc2195_pkg::sample_t got,
		input ltc2195_pkg::sample_t exp, input string what);
		if (got !== exp)
			stop_on_error($sformatf("MISMATCH at %0t: %s sample got %h expected %h",
				$time, what, got, exp));
	endtask

	//////////////////////////////
	// Stimulus
	task automatic send_command(input logic [15:0] addr, input ltc2195_pkg::reg_data_t data);
		@(posedge clk_in);
		cmd_trig <= 1'b1;
		cmd_addr <= addr;
		cmd_data <= data;
		@(posedge clk_in);
		cmd_trig <= 1'b0;
	endtask

	// Each valid write follows an ignored one with a foreign code byte
	task automatic run_commands();
		logic [31:0] r;
		logic [15:0] addr;
		int i;
		wait (frames_done == 3);                    // Power-up writes done
		for (i = 0; i < 4; i++) begin
			r = next_rand();
			addr = {(r[31:24] == `LTC_CMD_WRITE) ? 8'h30 : r[31:24], r[23:16]};
			send_command(addr, r[7:0]);
			repeat (20) @(posedge clk_in);
			r = next_rand();
			addr = {`LTC_CMD_WRITE, r[15:8]};
			exp_spi_q.push_back(expected_write(addr, r[7:0]));
			send_command(addr, r[7:0]);
			wait (frames_done == 4 + i);            // SCS rise ends the write
		end
		cmds_done = 1'b1;
	endtask

	// Random bit offset first and then one sample pair per word sent MSB first
	task automatic send_stream();
		logic [31:0] r;
		logic [15:0] ab0;
		logic [15:0] ab1;
		int off;
		int b;
		r = next_rand();
		off = int'(r[2:0]);
		$display("Serial stream offset %0d bits", off);
		repeat (off) begin
			@(posedge clk_in);
			ser_in <= '0;
		end
		while (!(cmds_done && words_sent >= N_WORDS)) begin
			r = next_rand();
			sent_q.push_back(r);                    // adc0 in the upper half
			words_sent++;
			ab0 = serialize_sample(r[31:16]);
			ab1 = serialize_sample(r[15:0]);
			for (b = `LTC_SER_BITS - 1; b >= 0; b--) begin
				@(posedge clk_in);
				ser_in <= {FRAME_PAT[b], ab1[b], ab1[8+b], ab0[b], ab0[8+b]};
			end
		end
	endtask

	//////////////////////////////
	// Monitors sample on the falling clock edge
	always @(negedge clk_in) begin
		if (!spi_scs && scs_d)
			spi_bits = 0;                           // Frame start
		if (!spi_scs && spi_sck && !sck_d) begin
			spi_shift = {spi_shift[14:0], spi_sdo}; // ADC samples SDO on SCK rise
			spi_bits++;
		end
		if (spi_scs && !scs_d) begin
			if (spi_bits != `LTC_SPI_WIDTH)
				stop_on_error($sformatf("SPI frame ending at %0t had %0d clock pulses",
					$time, spi_bits));
			else if (exp_spi_q.size() == 0)
				stop_on_error($sformatf("SPI frame %h at %0t with no write pending",
					spi_shift, $time));
			else begin
				check_spi(spi_shift, exp_spi_q.pop_front());
				frames_done++;
			end
		end
		sck_d = spi_sck;
		scs_d = spi_scs;
	end

	always @(negedge clk_in) begin
		logic [31:0] got;
		got = {adc0_sample, adc1_sample};
		if (sample_valid) begin
			if (synced) begin
				if (next_idx >= sent_q.size())
					stop_on_error("Sample strobe with no sent word left to compare");
				else begin
					check_sample(adc0_sample, sent_q[next_idx][31:16], "adc0");
					check_sample(adc1_sample, sent_q[next_idx][15:0], "adc1");
					next_idx++;
				end
			end else if (sent_q.size() >= 2 && got == sent_q[sent_q.size()-2]) begin
				next_idx = sent_q.size() - 1;       // Next word already pushed
				synced = 1'b1;
			end else if (sent_q.size() >= 1 && got == sent_q[sent_q.size()-1]) begin
				next_idx = sent_q.size();
				synced = 1'b1;
			end else begin
				stop_on_error($sformatf("MISMATCH at %0t: first sample pair %h not sent last",
					$time, got));
			end
			n_samples++;
		end
	end

	// One extra word since the next one is pushed before lock can show
	always @(negedge clk_in) begin
		if (!locked && words_sent > LOCK_WORDS + 1)
			stop_on_error($sformatf("Frame aligner still unlocked after %0d words",
				words_sent - 1));
	end

	//////////////////////////////
	// Clock, watchdog and main sequence
	initial begin
		clk_in = 1'b0;
		forever #(CLK_PERIOD/2) clk_in = ~clk_in;
	end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		stop_on_error("Timeout, the run did not finish in the allowed time");
	end

	initial begin
		rst_in   <= 1'b1;
		cmd_trig <= 1'b0;
		cmd_addr <= '0;
		cmd_data <= '0;
		ser_in   <= '0;
		exp_spi_q.push_back(`LTC_INIT_RESET);
		exp_spi_q.push_back(`LTC_INIT_FORMAT);
		exp_spi_q.push_back(`LTC_INIT_LANES);
		repeat (5) @(posedge clk_in);
		if (spi_scs !== 1'b1 || spi_sck !== 1'b0 || spi_sdo !== 1'b0 ||
			sample_valid !== 1'b0 || locked !== 1'b0)
			stop_on_error("Outputs not inactive during reset");
		rst_in <= 1'b0;
		fork
			send_stream();
			run_commands();
		join
		@(negedge clk_in);
		if (frames_done != 7 || exp_spi_q.size() != 0)
			stop_on_error($sformatf("%0d SPI frames seen, %0d writes never sent",
				frames_done, exp_spi_q.size()));
		else if (n_samples < MIN_SAMPLES)
			stop_on_error($sformatf("Only %0d samples received", n_samples));
		else begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
